// ==== Bender.yml ====
package:
  name: edge_sobel

sources:
  - files:
      - verilog/video_pkg.sv
      - verilog/sobel_cfg_pkg.sv
      - verilog/sobel_cfg_regs.sv
      - verilog/line_window.sv
      - verilog/sobel_kernel.sv
      - verilog/edge_sobel_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_edge_sobel.sv

// ==== sources.f ====
+incdir+include
verilog/video_pkg.sv
verilog/sobel_cfg_pkg.sv
verilog/sobel_cfg_regs.sv
verilog/line_window.sv
verilog/sobel_kernel.sv
verilog/edge_sobel_top.sv
verification/tb_edge_sobel.sv

// ==== include/sobel_ref_model.svh ====
// ----------------------------
// Sobel reference model, frame
// store and config mirror
// ----------------------------
`ifndef SOBEL_REF_MODEL_SVH
`define SOBEL_REF_MODEL_SVH

video_pkg::pix_t           model_frame [video_pkg::FRAME_ROWS][video_pkg::FRAME_COLS];
sobel_cfg_pkg::sobel_cfg_t model_staged;
sobel_cfg_pkg::sobel_cfg_t model_active;

function automatic void model_reset();
  model_staged = sobel_cfg_pkg::CFG_RESET;
  model_active = sobel_cfg_pkg::CFG_RESET;
endfunction

// call before model_cfg_write when both fall in one cycle
function automatic void model_frame_start();
  model_active = model_staged;
endfunction

function automatic void model_cfg_write(input logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] addr,
                                        input video_pkg::pix_t data);
  if (addr == sobel_cfg_pkg::ADDR_THRESH) begin
    model_staged.threshold = data;
  end else if (addr == sobel_cfg_pkg::ADDR_MODE) begin
    if (data inside {sobel_cfg_pkg::MODE_MAG, sobel_cfg_pkg::MODE_BINARY,
                     sobel_cfg_pkg::MODE_BYPASS}) begin
      model_staged.mode = sobel_cfg_pkg::edge_mode_t'(data[1:0]);
    end
  end
endfunction

function automatic void model_store(input int row, input int col, input video_pkg::pix_t pix);
  model_frame[row][col] = pix;
endfunction

// outside the frame reads as zero
function automatic int model_tap(input int row, input int col);
  if (row < 0 || col < 0) begin
    return 0;
  end
  return int'(model_frame[row][col]);
endfunction

// expected output for the pixel at (row, col), store it first
function automatic video_pkg::pix_t model_pixel(input int row, input int col);
  int gx;
  int gy;
  int s;
  gx = model_tap(row - 2, col) + 2 * model_tap(row - 1, col) + model_tap(row, col)
     - model_tap(row - 2, col - 2) - 2 * model_tap(row - 1, col - 2) - model_tap(row, col - 2);
  gy = model_tap(row, col - 2) + 2 * model_tap(row, col - 1) + model_tap(row, col)
     - model_tap(row - 2, col - 2) - 2 * model_tap(row - 2, col - 1) - model_tap(row - 2, col);
  s = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
  case (model_active.mode)
    sobel_cfg_pkg::MODE_MAG:    return (s > int'(model_active.threshold)) ? 8'hff : 8'(s);
    sobel_cfg_pkg::MODE_BINARY: return (s > int'(model_active.threshold)) ? 8'hff : 8'h00;
    sobel_cfg_pkg::MODE_BYPASS: return 8'(model_tap(row - 1, col - 1));
    default:                    return 8'h00;
  endcase
endfunction

`endif

// ==== verification/tb_edge_sobel.sv ====
// ----------------------------
// Sobel edge detector testbench
// random frames against a model
// ----------------------------
`timescale 1ns/100ps

module tb_edge_sobel;

  localparam logic [31:0] SEED          = 32'h2ba065d6;
  localparam int          NUM_FRAMES    = 9;
  localparam int          IDLE_CYCLES   = 8;
  localparam int          LATENCY       = 3;
  localparam int          DRAIN_TIMEOUT = 50;

  typedef struct packed {
    logic [31:0]          cycle;
    logic [7:0]           frame;
    video_pkg::vid_beat_t beat;
  } exp_entry_t;

  logic                                 pclk = 1'b0;
  logic                                 reset;
  video_pkg::vid_beat_t                 video_in;
  logic                                 cfg_wr;
  logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr;
  video_pkg::pix_t                      cfg_data;
  video_pkg::vid_beat_t                 video_out;

  exp_entry_t  exp_q[$];
  exp_entry_t  head;
  logic [31:0] cycle_cnt;
  logic        record_en;
  logic        fsync_prev;
  int          frame_idx;
  int          check_cnt;
  int          unmapped_writes;

  `include "sobel_ref_model.svh"

  always #2 pclk = ~pclk;

  edge_sobel_top DUT (
    .pclk_i     (pclk),
    .reset_i    (reset),
    .video_i    (video_in),
    .cfg_wr_i   (cfg_wr),
    .cfg_addr_i (cfg_addr),
    .cfg_data_i (cfg_data),
    .video_o    (video_out)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error [%s] expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
    end else begin
      check_cnt++;
    end
  endtask

  // drive one input cycle and queue the model's expected output
  task automatic drive_cycle(input logic fs, input logic rs, input video_pkg::pix_t pix,
                             input int row, input int col, input logic wr,
                             input logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] addr,
                             input video_pkg::pix_t data);
    video_pkg::vid_beat_t beat;
    exp_entry_t           entry;
    beat.fsync = fs;
    beat.rsync = rs;
    beat.pix   = pix;
    @(posedge pclk);
    video_in <= beat;
    cfg_wr   <= wr;
    cfg_addr <= addr;
    cfg_data <= data;
    cycle_cnt = cycle_cnt + 1;
    // frame start is taken before a write in the same cycle
    if (fs && !fsync_prev) begin
      model_frame_start();
    end
    fsync_prev = fs;
    if (wr) begin
      model_cfg_write(addr, data);
      if (addr != sobel_cfg_pkg::ADDR_THRESH && addr != sobel_cfg_pkg::ADDR_MODE) begin
        unmapped_writes++;
      end
    end
    entry.cycle      = cycle_cnt;
    entry.frame      = 8'(frame_idx);
    entry.beat       = '0;
    entry.beat.fsync = fs;
    entry.beat.rsync = rs;
    if (fs && rs) begin
      model_store(row, col, pix);
      entry.beat.pix = model_pixel(row, col);
    end
    if (record_en) begin
      exp_q.push_back(entry);
    end
  endtask

  task automatic drive_random_cycle(input logic fs, input logic rs, input int row,
                                    input int col, input int wr_pct);
    logic                                 wr;
    logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] addr;
    video_pkg::pix_t                      data;
    video_pkg::pix_t                      pix;
    pix  = 8'($urandom_range(255));
    wr   = ($urandom_range(99) < wr_pct);
    addr = 2'($urandom_range(3));
    // mode codes 0 to 3 where 3 is invalid
    if (addr == sobel_cfg_pkg::ADDR_MODE) begin
      data = 8'($urandom_range(3));
    end else begin
      data = 8'($urandom_range(255));
    end
    // the threshold only changes inside a frame
    if (!fs && addr == sobel_cfg_pkg::ADDR_THRESH) begin
      wr = 1'b0;
    end
    drive_cycle(fs, rs, pix, row, col, wr, addr, data);
  endtask

  task automatic run_frame(input int frame);
    int gap;
    int lead;
    frame_idx = frame;
    gap       = $urandom_range(10, 6);
    for (int i = 0; i < gap - 1; i++) begin
      drive_random_cycle(1'b0, 1'b0, -1, -1, 30);
    end
    // mode for this frame in the last gap cycle
    drive_cycle(1'b0, 1'b0, '0, -1, -1, 1'b1, sobel_cfg_pkg::ADDR_MODE, 8'(frame % 3));
    for (int r = 0; r < video_pkg::FRAME_ROWS; r++) begin
      lead = $urandom_range(4, 1);
      for (int i = 0; i < lead; i++) begin
        if (r == video_pkg::FRAME_ROWS / 2 && i == 0) begin
          // threshold for the next frame
          drive_cycle(1'b1, 1'b0, '0, r, -1, 1'b1, sobel_cfg_pkg::ADDR_THRESH,
                      8'($urandom_range(255)));
        end else begin
          drive_random_cycle(1'b1, 1'b0, r, -1, 5);
        end
      end
      for (int c = 0; c < video_pkg::FRAME_COLS; c++) begin
        drive_random_cycle(1'b1, 1'b1, r, c, 2);
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      drive_cycle(1'b0, 1'b0, '0, -1, -1, 1'b0, '0, '0);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d expected output beats never left the DUT", exp_q.size());
      $display("TEST FAIL");
      $fatal(1, "output drain timed out");
    end
  endtask

  // output of the beat driven LATENCY edges earlier
  always @(negedge pclk) begin
    if (exp_q.size() != 0 && exp_q[0].cycle + LATENCY == cycle_cnt) begin
      head = exp_q.pop_front();
      check_value($sformatf("frame %0d beat %0d", head.frame, head.cycle),
                  head.beat, video_out);
    end
  end

  initial begin
    void'($urandom(SEED));
    reset           = 1'b1;
    video_in        = '0;
    cfg_wr          = 1'b0;
    cfg_addr        = '0;
    cfg_data        = '0;
    cycle_cnt       = '0;
    record_en       = 1'b1;
    fsync_prev      = 1'b0;
    frame_idx       = 0;
    check_cnt       = 0;
    unmapped_writes = 0;
    model_reset();
    repeat (5) @(posedge pclk);
    reset <= 1'b0;
    // output stays idle while the input is quiet
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      drive_cycle(1'b0, 1'b0, '0, -1, -1, 1'b0, '0, '0);
    end
    for (int f = 0; f < NUM_FRAMES; f++) begin
      run_frame(f);
    end
    frame_idx = NUM_FRAMES;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      drive_random_cycle(1'b0, 1'b0, -1, -1, 30);
    end
    record_en = 1'b0;
    drain_outputs();
    check_value("unmapped writes made", 1, unmapped_writes > 0);
    $display("%0d checks done", check_cnt);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== verilog/edge_sobel_top.sv ====
// ----------------------------
// Sobel edge detector top level
// ----------------------------
`timescale 1ns/100ps

module edge_sobel_top (
  input  logic                                pclk_i,
  input  logic                                reset_i,
  input  video_pkg::vid_beat_t                video_i,
  input  logic                                cfg_wr_i,
  input  logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  video_pkg::pix_t                     cfg_data_i,
  output video_pkg::vid_beat_t                video_o
);

  video_pkg::vid_beat_t      win_beat;
  video_pkg::pix_window_t    window;
  sobel_cfg_pkg::sobel_cfg_t active_cfg;

  // 1 cycle
  line_window u_window (
    .pclk_i   (pclk_i),
    .reset_i  (reset_i),
    .video_i  (video_i),
    .beat_o   (win_beat),
    .window_o (window)
  );

  // 2 cycles
  sobel_kernel u_kernel (
    .pclk_i   (pclk_i),
    .reset_i  (reset_i),
    .beat_i   (win_beat),
    .window_i (window),
    .cfg_i    (active_cfg),
    .video_o  (video_o)
  );

  // frame start seen on the raw input fsync
  sobel_cfg_regs u_cfg (
    .pclk_i       (pclk_i),
    .reset_i      (reset_i),
    .cfg_wr_i     (cfg_wr_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .frame_sync_i (video_i.fsync),
    .active_cfg_o (active_cfg)
  );

endmodule

// ==== verilog/line_window.sv ====
// ----------------------------
// 3x3 window generator with two
// line buffers and zero borders
// ----------------------------
`timescale 1ns/100ps

module line_window (
  input  logic                   pclk_i,
  input  logic                   reset_i,
  input  video_pkg::vid_beat_t   video_i,
  output video_pkg::vid_beat_t   beat_o,
  output video_pkg::pix_window_t window_o
);

  logic                        valid;
  logic                        rsync_q;
  logic [video_pkg::COL_W-1:0] col_q;
  logic [video_pkg::ROW_W-1:0] row_q;

  // previous row and the one before it, indexed by column
  video_pkg::pix_t lb1_mem [video_pkg::FRAME_COLS];
  video_pkg::pix_t lb2_mem [video_pkg::FRAME_COLS];
  video_pkg::pix_t lb1_rd;
  video_pkg::pix_t lb2_rd;

  // column taps, [0] is one column back
  video_pkg::pix_t cur_sh [2];
  video_pkg::pix_t up1_sh [2];
  video_pkg::pix_t up2_sh [2];

  logic row_ok1;
  logic row_ok2;
  logic col_ok1;
  logic col_ok2;

  assign valid  = video_i.fsync & video_i.rsync;
  assign lb1_rd = lb1_mem[col_q];
  assign lb2_rd = lb2_mem[col_q];

  // border masks
  assign row_ok1 = (row_q != '0);
  assign row_ok2 = (row_q[video_pkg::ROW_W-1:1] != '0);
  assign col_ok1 = (col_q != '0);
  assign col_ok2 = (col_q[video_pkg::COL_W-1:1] != '0);

  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      rsync_q <= 1'b0;
      col_q   <= '0;
      row_q   <= '0;
    end else begin
      rsync_q <= video_i.rsync;
      if (!video_i.rsync) begin
        col_q <= '0;
      end else if (valid) begin
        col_q <= col_q + 1'b1;
      end
      // next row starts after rsync falls
      if (!video_i.fsync) begin
        row_q <= '0;
      end else if (rsync_q && !video_i.rsync) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  always_ff @(posedge pclk_i) begin
    if (valid) begin
      lb1_mem[col_q] <= video_i.pix;
      lb2_mem[col_q] <= lb1_rd;
      cur_sh[0]      <= video_i.pix;
      cur_sh[1]      <= cur_sh[0];
      up1_sh[0]      <= lb1_rd;
      up1_sh[1]      <= up1_sh[0];
      up2_sh[0]      <= lb2_rd;
      up2_sh[1]      <= up2_sh[0];
    end
  end

  // taps before row 0 or column 0 read as zero
  always_ff @(posedge pclk_i) begin
    if (valid) begin
      window_o.p9 <= video_i.pix;
      window_o.p8 <= col_ok1 ? cur_sh[0] : '0;
      window_o.p7 <= col_ok2 ? cur_sh[1] : '0;
      window_o.p6 <= row_ok1 ? lb1_rd : '0;
      window_o.p5 <= (row_ok1 && col_ok1) ? up1_sh[0] : '0;
      window_o.p4 <= (row_ok1 && col_ok2) ? up1_sh[1] : '0;
      window_o.p3 <= row_ok2 ? lb2_rd : '0;
      window_o.p2 <= (row_ok2 && col_ok1) ? up2_sh[0] : '0;
      window_o.p1 <= (row_ok2 && col_ok2) ? up2_sh[1] : '0;
    end
  end

  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      beat_o <= '0;
    end else begin
      beat_o <= video_i;
    end
  end

  a_rsync_in_frame: assert property (
    @(posedge pclk_i) disable iff (reset_i)
    video_i.rsync |-> video_i.fsync
  );

endmodule

// ==== verilog/sobel_cfg_pkg.sv ====
// ----------------------------
// Sobel configuration registers
// map, mode codes and reset values
// ----------------------------
package sobel_cfg_pkg;

  localparam int CFG_ADDR_W = 2;
  localparam int THRESH_W   = 8;

  // register map
  localparam logic [CFG_ADDR_W-1:0] ADDR_THRESH = 2'd0;
  localparam logic [CFG_ADDR_W-1:0] ADDR_MODE   = 2'd1;

  typedef enum logic [1:0] {
    MODE_MAG    = 2'd0,
    MODE_BINARY = 2'd1,
    MODE_BYPASS = 2'd2
  } edge_mode_t;

  localparam logic [THRESH_W-1:0] THRESH_RESET = 8'd127;
  localparam edge_mode_t          MODE_RESET   = MODE_MAG;

  typedef struct packed {
    logic [THRESH_W-1:0] threshold;
    edge_mode_t          mode;
  } sobel_cfg_t;

  localparam sobel_cfg_t CFG_RESET = '{
    threshold: THRESH_RESET,
    mode:      MODE_RESET
  };

endpackage

// ==== verilog/sobel_cfg_regs.sv ====
// ----------------------------
// Sobel config registers with a
// frame-start shadow copy
// ----------------------------
`timescale 1ns/100ps

module sobel_cfg_regs (
  input  logic                                pclk_i,
  input  logic                                reset_i,
  input  logic                                cfg_wr_i,
  input  logic [sobel_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  video_pkg::pix_t                     cfg_data_i,
  input  logic                                frame_sync_i,
  output sobel_cfg_pkg::sobel_cfg_t           active_cfg_o
);

  sobel_cfg_pkg::sobel_cfg_t staged_q;
  sobel_cfg_pkg::sobel_cfg_t active_q;
  logic                      fsync_q;
  logic                      frame_start;
  logic                      mode_ok;

  // only the three defined mode codes are accepted
  assign mode_ok = cfg_data_i inside {sobel_cfg_pkg::MODE_MAG,
                                      sobel_cfg_pkg::MODE_BINARY,
                                      sobel_cfg_pkg::MODE_BYPASS};

  assign frame_start  = frame_sync_i & ~fsync_q;
  assign active_cfg_o = active_q;

  // staging side, written by the bus
  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      staged_q <= sobel_cfg_pkg::CFG_RESET;
    end else if (cfg_wr_i) begin
      case (cfg_addr_i)
        sobel_cfg_pkg::ADDR_THRESH: begin
          staged_q.threshold <= cfg_data_i;
        end
        sobel_cfg_pkg::ADDR_MODE: begin
          if (mode_ok) begin
            staged_q.mode <= sobel_cfg_pkg::edge_mode_t'(cfg_data_i[1:0]);
          end
        end
        // unmapped addresses are dropped
        default: ;
      endcase
    end
  end

  // active copy follows staging only at frame start, so a write in
  // that same cycle waits for the next frame
  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      fsync_q  <= 1'b0;
      active_q <= sobel_cfg_pkg::CFG_RESET;
    end else begin
      fsync_q <= frame_sync_i;
      if (frame_start) begin
        active_q <= staged_q;
      end
    end
  end

  a_wr_addr_known: assert property (
    @(posedge pclk_i) disable iff (reset_i)
    cfg_wr_i |-> !$isunknown(cfg_addr_i)
  );

endmodule

// ==== verilog/sobel_kernel.sv ====
// ----------------------------
// two-stage Sobel gradient with
// mode and threshold shaping
// ----------------------------
`timescale 1ns/100ps

module sobel_kernel (
  input  logic                      pclk_i,
  input  logic                      reset_i,
  input  video_pkg::vid_beat_t      beat_i,
  input  video_pkg::pix_window_t    window_i,
  input  sobel_cfg_pkg::sobel_cfg_t cfg_i,
  output video_pkg::vid_beat_t      video_o
);

  logic signed [video_pkg::GRAD_W-1:0] gx_c;
  logic signed [video_pkg::GRAD_W-1:0] gy_c;
  logic signed [video_pkg::GRAD_W-1:0] gx_q;
  logic signed [video_pkg::GRAD_W-1:0] gy_q;
  logic        [video_pkg::GRAD_W-1:0] abs_x;
  logic        [video_pkg::GRAD_W-1:0] abs_y;
  logic        [video_pkg::GRAD_W-1:0] sum_c;
  logic        [video_pkg::GRAD_W-1:0] thresh_ext;
  logic                                over_thr;
  video_pkg::pix_t                     centre_q;
  logic                                fsync_q;
  logic                                rsync_q;

  // zero-extend a pixel into the signed gradient width
  function automatic logic signed [video_pkg::GRAD_W-1:0] widen(input video_pkg::pix_t p);
    return $signed({{(video_pkg::GRAD_W - video_pkg::PIX_W){1'b0}}, p});
  endfunction

  always_comb begin
    gx_c = widen(window_i.p3) + (widen(window_i.p6) <<< 1) + widen(window_i.p9)
         - widen(window_i.p1) - (widen(window_i.p4) <<< 1) - widen(window_i.p7);
    gy_c = widen(window_i.p7) + (widen(window_i.p8) <<< 1) + widen(window_i.p9)
         - widen(window_i.p1) - (widen(window_i.p2) <<< 1) - widen(window_i.p3);
  end

  // stage 1
  always_ff @(posedge pclk_i) begin
    gx_q     <= gx_c;
    gy_q     <= gy_c;
    centre_q <= window_i.p5;
  end

  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      fsync_q <= 1'b0;
      rsync_q <= 1'b0;
    end else begin
      fsync_q <= beat_i.fsync;
      rsync_q <= beat_i.rsync;
    end
  end

  // |gx| + |gy| tops out at 2040, still inside GRAD_W
  assign abs_x      = $unsigned(gx_q[video_pkg::GRAD_W-1] ? -gx_q : gx_q);
  assign abs_y      = $unsigned(gy_q[video_pkg::GRAD_W-1] ? -gy_q : gy_q);
  assign sum_c      = abs_x + abs_y;
  assign thresh_ext = {{(video_pkg::GRAD_W - sobel_cfg_pkg::THRESH_W){1'b0}}, cfg_i.threshold};
  assign over_thr   = (sum_c > thresh_ext);

  // stage 2
  always_ff @(posedge pclk_i) begin
    if (reset_i) begin
      video_o <= '0;
    end else begin
      video_o.fsync <= fsync_q;
      video_o.rsync <= rsync_q;
      if (!rsync_q) begin
        video_o.pix <= '0;
      end else begin
        case (cfg_i.mode)
          // below threshold the sum fits in a pixel
          sobel_cfg_pkg::MODE_MAG:    video_o.pix <= over_thr ? '1 : sum_c[video_pkg::PIX_W-1:0];
          sobel_cfg_pkg::MODE_BINARY: video_o.pix <= over_thr ? '1 : '0;
          sobel_cfg_pkg::MODE_BYPASS: video_o.pix <= centre_q;
          default:                    video_o.pix <= '0;
        endcase
      end
    end
  end

  // relies on the window stage keeping rows inside frames
  a_no_pix_outside_frame: assert property (
    @(posedge pclk_i) disable iff (reset_i)
    !video_o.fsync |-> (!video_o.rsync && (video_o.pix == '0))
  );

endmodule

// ==== verilog/video_pkg.sv ====
// ----------------------------
// video stream types and the
// fixed frame geometry
// ----------------------------
package video_pkg;

  // pixel and frame size
  localparam int PIX_W      = 8;
  localparam int FRAME_COLS = 16;
  localparam int FRAME_ROWS = 12;

  // counter widths
  localparam int COL_W = $clog2(FRAME_COLS);
  localparam int ROW_W = $clog2(FRAME_ROWS + 1);

  // signed gradient, also wide enough for |gx| + |gy|
  localparam int GRAD_W = PIX_W + 3;

  typedef logic [PIX_W-1:0] pix_t;

  // one stream cycle, pixel valid when both syncs are high
  typedef struct packed {
    logic fsync;
    logic rsync;
    pix_t pix;
  } vid_beat_t;

  // 3x3 neighbourhood, oldest row first
  // p9 is the newest pixel, p5 the centre
  typedef struct packed {
    pix_t p1;
    pix_t p2;
    pix_t p3;
    pix_t p4;
    pix_t p5;
    pix_t p6;
    pix_t p7;
    pix_t p8;
    pix_t p9;
  } pix_window_t;

endpackage
